// File: flist.f
logic/cpu_types_pkg.sv
logic/bus_pkg.sv
logic/register_file.sv
logic/control_unit.sv
logic/alu.sv
logic/datapath.sv
logic/memory_arbiter.sv
logic/cpu_top.sv
verif/cpu_sva.sv
verif/cpu_tb.sv

// File: logic/alu.sv
`timescale 1ns/1ps

module alu
	import cpu_types_pkg::*;
(
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic [2:0]  op,
	output logic [31:0] result,
	output logic        zero
);

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			// signed compare
			ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
			// immediate moves to the upper half
			ALU_LUI: result = {b[15:0], 16'd0};
			default: result = '0;
		endcase
	end

	assign zero = (result == 32'd0);

endmodule

// File: logic/bus_pkg.sv
package bus_pkg;

	// data word and byte address widths
	localparam int WORD_WIDTH = 32;
	localparam int ADDR_WIDTH = 32;

	// bytes per word
	localparam int WORD_BYTES = 4;

	// byte offset bits inside a word, ignored by memory
	localparam int BYTE_OFFSET = 2;

endpackage

// File: logic/control_unit.sv
`timescale 1ns/1ps

module control_unit
	import cpu_types_pkg::*;
(
	input  instr_t     instr,
	output logic [2:0] alu_op,
	output logic       alu_src_imm,
	output logic       zero_extend,
	output logic       reg_dst_rd,
	output logic       reg_write,
	output logic       mem_read,
	output logic       mem_write,
	output logic       branch,
	output logic       branch_ne,
	output logic       jump,
	output logic       halt_op
);

	always_comb begin
		// defaults make unknown codes a no-op
		alu_op      = ALU_ADD;
		alu_src_imm = 1'b0;
		zero_extend = 1'b0;
		reg_dst_rd  = 1'b0;
		reg_write   = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		branch      = 1'b0;
		branch_ne   = 1'b0;
		jump        = 1'b0;
		halt_op     = 1'b0;

		case (instr.r.opcode)
			OP_RTYPE: begin
				reg_dst_rd = 1'b1;
				reg_write  = 1'b1;
				case (instr.r.funct)
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_SLT:  alu_op = ALU_SLT;
					default: reg_write = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				alu_src_imm = 1'b1;
				reg_write   = 1'b1;
			end
			OP_ORI: begin
				alu_op      = ALU_OR;
				alu_src_imm = 1'b1;
				zero_extend = 1'b1;
				reg_write   = 1'b1;
			end
			OP_LUI: begin
				alu_op      = ALU_LUI;
				alu_src_imm = 1'b1;
				reg_write   = 1'b1;
			end
			OP_LW: begin
				alu_src_imm = 1'b1;
				reg_write   = 1'b1;
				mem_read    = 1'b1;
			end
			OP_SW: begin
				alu_src_imm = 1'b1;
				mem_write   = 1'b1;
			end
			// branches compare rs and rt through a subtract
			OP_BEQ: begin
				alu_op = ALU_SUB;
				branch = 1'b1;
			end
			OP_BNE: begin
				alu_op    = ALU_SUB;
				branch    = 1'b1;
				branch_ne = 1'b1;
			end
			OP_J:    jump = 1'b1;
			OP_HALT: halt_op = 1'b1;
			default: ;
		endcase
	end

endmodule

// File: logic/cpu_top.sv
`timescale 1ns/1ps

module cpu_top
	import bus_pkg::*;
#(
	parameter logic [31:0] PC_INIT = 32'h0
) (
	input  logic                  CLK,
	input  logic                  nRST,
	output logic                  halt,
	output logic                  wb_cyc,
	output logic                  wb_stb,
	output logic                  wb_we,
	output logic [ADDR_WIDTH-1:0] wb_adr,
	output logic [WORD_WIDTH-1:0] wb_dat_w,
	input  logic [WORD_WIDTH-1:0] wb_dat_r,
	input  logic                  wb_ack
);

	logic                  imem_ren, ihit, dmem_ren, dmem_wen, dhit;
	logic [ADDR_WIDTH-1:0] imem_addr, dmem_addr;
	logic [WORD_WIDTH-1:0] imem_load, dmem_load, dmem_store;

	datapath #(
		.PC_INIT (PC_INIT)
	) u_datapath (
		.CLK        (CLK),
		.nRST       (nRST),
		.imem_ren   (imem_ren),
		.imem_addr  (imem_addr),
		.imem_load  (imem_load),
		.ihit       (ihit),
		.dmem_ren   (dmem_ren),
		.dmem_wen   (dmem_wen),
		.dmem_addr  (dmem_addr),
		.dmem_store (dmem_store),
		.dmem_load  (dmem_load),
		.dhit       (dhit),
		.halt       (halt)
	);

	memory_arbiter u_memory_arbiter (
		.CLK        (CLK),
		.nRST       (nRST),
		.imem_ren   (imem_ren),
		.imem_addr  (imem_addr),
		.imem_load  (imem_load),
		.ihit       (ihit),
		.dmem_ren   (dmem_ren),
		.dmem_wen   (dmem_wen),
		.dmem_addr  (dmem_addr),
		.dmem_store (dmem_store),
		.dmem_load  (dmem_load),
		.dhit       (dhit),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack)
	);

endmodule

// File: logic/cpu_types_pkg.sv
package cpu_types_pkg;

	// primary opcodes
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_LUI   = 6'h0f;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;
	localparam logic [5:0] OP_HALT  = 6'h3f;

	// function codes, r-type only
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_SLT  = 6'h2a;

	// alu operations
	localparam logic [2:0] ALU_ADD = 3'd0;
	localparam logic [2:0] ALU_SUB = 3'd1;
	localparam logic [2:0] ALU_AND = 3'd2;
	localparam logic [2:0] ALU_OR  = 3'd3;
	localparam logic [2:0] ALU_SLT = 3'd4;
	localparam logic [2:0] ALU_LUI = 3'd5;

	// one instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i;
		struct packed {
			logic [5:0]  opcode;
			logic [25:0] target;
		} j;
	} instr_t;

endpackage

// File: logic/datapath.sv
`timescale 1ns/1ps

module datapath
	import cpu_types_pkg::*;
	import bus_pkg::*;
#(
	parameter logic [31:0] PC_INIT = 32'h0
) (
	input  logic        CLK,
	input  logic        nRST,
	output logic        imem_ren,
	output logic [31:0] imem_addr,
	input  logic [31:0] imem_load,
	input  logic        ihit,
	output logic        dmem_ren,
	output logic        dmem_wen,
	output logic [31:0] dmem_addr,
	output logic [31:0] dmem_store,
	input  logic [31:0] dmem_load,
	input  logic        dhit,
	output logic        halt
);

	localparam logic [1:0] S_FETCH   = 2'd0;
	localparam logic [1:0] S_EXECUTE = 2'd1;
	localparam logic [1:0] S_MEMORY  = 2'd2;
	localparam logic [1:0] S_HALTED  = 2'd3;

	logic [1:0]  state, next_state;
	logic [31:0] pc, next_pc, pc_plus4;
	instr_t      ir;

	logic [2:0]  alu_op;
	logic        alu_src_imm, zero_extend, reg_dst_rd, reg_write;
	logic        mem_read, mem_write, branch, branch_ne, jump, halt_op;

	logic [31:0] rdat1, rdat2, imm_ext, alu_b, alu_result, wdat;
	logic        alu_zero, taken, pc_wen, rf_wen;
	logic [4:0]  wsel;

	register_file u_register_file (
		.CLK   (CLK),
		.nRST  (nRST),
		.rsel1 (ir.r.rs),
		.rsel2 (ir.r.rt),
		.wsel  (wsel),
		.wen   (rf_wen),
		.wdat  (wdat),
		.rdat1 (rdat1),
		.rdat2 (rdat2)
	);

	control_unit u_control_unit (
		.instr       (ir),
		.alu_op      (alu_op),
		.alu_src_imm (alu_src_imm),
		.zero_extend (zero_extend),
		.reg_dst_rd  (reg_dst_rd),
		.reg_write   (reg_write),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.branch      (branch),
		.branch_ne   (branch_ne),
		.jump        (jump),
		.halt_op     (halt_op)
	);

	assign imm_ext = zero_extend ? {16'd0, ir.i.imm} : {{16{ir.i.imm[15]}}, ir.i.imm};
	assign alu_b   = alu_src_imm ? imm_ext : rdat2;

	alu u_alu (
		.a      (rdat1),
		.b      (alu_b),
		.op     (alu_op),
		.result (alu_result),
		.zero   (alu_zero)
	);

	// next pc selection
	assign pc_plus4 = pc + WORD_BYTES;
	assign taken    = branch && (alu_zero ^ branch_ne);
	always_comb begin
		if (jump)
			next_pc = {pc_plus4[31:28], ir.j.target, {BYTE_OFFSET{1'b0}}};
		else if (taken)
			next_pc = pc_plus4 + (imm_ext << BYTE_OFFSET);
		else
			next_pc = pc_plus4;
	end

	// memory ops finish on dhit, everything else at execute
	assign pc_wen = (state == S_EXECUTE && !mem_read && !mem_write && !halt_op) ||
		(state == S_MEMORY && dhit);
	assign rf_wen = reg_write && ((state == S_EXECUTE && !mem_read) ||
		(state == S_MEMORY && dhit));
	assign wsel   = reg_dst_rd ? ir.r.rd : ir.r.rt;
	assign wdat   = mem_read ? dmem_load : alu_result;

	always_comb begin
		next_state = state;
		case (state)
			S_FETCH:   if (ihit) next_state = S_EXECUTE;
			S_EXECUTE: begin
				if (halt_op)
					next_state = S_HALTED;
				else if (mem_read || mem_write)
					next_state = S_MEMORY;
				else
					next_state = S_FETCH;
			end
			S_MEMORY:  if (dhit) next_state = S_FETCH;
			default:   next_state = S_HALTED;
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= S_FETCH;
			pc    <= PC_INIT;
		end else begin
			state <= next_state;
			if (pc_wen)
				pc <= next_pc;
		end
	end

	// instruction register
	always_ff @(posedge CLK) begin
		if (state == S_FETCH && ihit)
			ir <= imem_load;
	end

	assign imem_ren   = (state == S_FETCH);
	assign imem_addr  = pc;
	assign dmem_ren   = (state == S_MEMORY) && mem_read;
	assign dmem_wen   = (state == S_MEMORY) && mem_write;
	assign dmem_addr  = alu_result;
	assign dmem_store = rdat2;
	assign halt       = (state == S_HALTED);

endmodule

// File: logic/memory_arbiter.sv
`timescale 1ns/1ps

module memory_arbiter
	import bus_pkg::*;
(
	input  logic                  CLK,
	input  logic                  nRST,
	input  logic                  imem_ren,
	input  logic [ADDR_WIDTH-1:0] imem_addr,
	output logic [WORD_WIDTH-1:0] imem_load,
	output logic                  ihit,
	input  logic                  dmem_ren,
	input  logic                  dmem_wen,
	input  logic [ADDR_WIDTH-1:0] dmem_addr,
	input  logic [WORD_WIDTH-1:0] dmem_store,
	output logic [WORD_WIDTH-1:0] dmem_load,
	output logic                  dhit,
	output logic                  wb_cyc,
	output logic                  wb_stb,
	output logic                  wb_we,
	output logic [ADDR_WIDTH-1:0] wb_adr,
	output logic [WORD_WIDTH-1:0] wb_dat_w,
	input  logic [WORD_WIDTH-1:0] wb_dat_r,
	input  logic                  wb_ack
);

	logic busy;
	// set while the running cycle belongs to the data side
	logic data_sel;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			busy     <= 1'b0;
			data_sel <= 1'b0;
			wb_we    <= 1'b0;
		end else if (!busy) begin
			if (dmem_ren || dmem_wen) begin
				busy     <= 1'b1;
				data_sel <= 1'b1;
				wb_we    <= dmem_wen;
			end else if (imem_ren) begin
				busy     <= 1'b1;
				data_sel <= 1'b0;
				wb_we    <= 1'b0;
			end
		end else if (wb_ack) begin
			// cycle done, idle for at least one clock
			busy  <= 1'b0;
			wb_we <= 1'b0;
		end
	end

	// address and write data held for the whole cycle
	always_ff @(posedge CLK) begin
		if (!busy) begin
			wb_adr   <= (dmem_ren || dmem_wen) ? dmem_addr : imem_addr;
			wb_dat_w <= dmem_store;
		end
	end

	assign wb_cyc    = busy;
	assign wb_stb    = busy;
	assign ihit      = busy && !data_sel && wb_ack;
	assign dhit      = busy && data_sel && wb_ack;
	assign imem_load = wb_dat_r;
	assign dmem_load = wb_dat_r;

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic        CLK,
	input  logic        nRST,
	input  logic [4:0]  rsel1,
	input  logic [4:0]  rsel2,
	input  logic [4:0]  wsel,
	input  logic        wen,
	input  logic [31:0] wdat,
	output logic [31:0] rdat1,
	output logic [31:0] rdat2
);

	logic [31:0] regs [32];

	// register 0 is never written, so it stays zero after reset
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int k = 0; k < 32; k++) begin
				regs[k] <= '0;
			end
		end else if (wen && (wsel != 5'd0)) begin
			regs[wsel] <= wdat;
		end
	end

	// combinational reads
	assign rdat1 = regs[rsel1];
	assign rdat2 = regs[rsel2];

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu_tb -f flist.f -o cpu_sim

out=$(./obj_dir/cpu_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Finished with no errors'; then
	exit 0
fi
exit 1

// File: verif/cpu_sva.sv
`timescale 1ns/1ps

module cpu_sva
	import bus_pkg::*;
(
	input logic                  CLK,
	input logic                  nRST,
	input logic                  halt,
	input logic                  wb_cyc,
	input logic                  wb_stb,
	input logic                  wb_we,
	input logic [ADDR_WIDTH-1:0] wb_adr,
	input logic [WORD_WIDTH-1:0] wb_dat_w,
	input logic                  wb_ack
);

	a_stb_cyc: assert property (@(posedge CLK) disable iff (!nRST) wb_stb |-> wb_cyc)
		else $error("wishbone stb raised without cyc");

	// write data only matters on a write
	a_stable: assert property (@(posedge CLK) disable iff (!nRST)
		(wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) &&
		(!wb_we || $stable(wb_dat_w))))
		else $error("wishbone request changed before ack");

	a_drop: assert property (@(posedge CLK) disable iff (!nRST) (wb_stb && wb_ack) |=> !wb_stb)
		else $error("wishbone stb held after ack");

	a_halt: assert property (@(posedge CLK) disable iff (!nRST) halt |-> !wb_stb)
		else $error("wishbone stb while halted");

endmodule

bind cpu_top cpu_sva i_sva (
	.CLK      (CLK),
	.nRST     (nRST),
	.halt     (halt),
	.wb_cyc   (wb_cyc),
	.wb_stb   (wb_stb),
	.wb_we    (wb_we),
	.wb_adr   (wb_adr),
	.wb_dat_w (wb_dat_w),
	.wb_ack   (wb_ack)
);

// File: verif/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb
	import cpu_types_pkg::*;
	import bus_pkg::*;
();

	localparam logic [31:0] PC_INIT    = 32'h0;
	localparam int          MEM_WORDS  = 1024;
	localparam int          RAND_INSTR = 60;
	localparam int          DATA_BASE  = 2048;
	localparam int          DUMP_BASE  = 3072;
	localparam int          TIMEOUT    = 20000;

	logic                  CLK, nRST, halt, wb_cyc, wb_stb, wb_we, wb_ack;
	logic [ADDR_WIDTH-1:0] wb_adr;
	logic [WORD_WIDTH-1:0] wb_dat_w, wb_dat_r;

	integer      seed;
	int          errors;
	logic [31:0] mem [MEM_WORDS];
	logic [31:0] ref_mem [MEM_WORDS];
	logic [31:0] ref_regs [32];
	logic        in_cycle;
	logic [31:0] ack_delay;

	// reference bus trace, one entry per wishbone cycle
	logic        exp_we [$];
	logic [31:0] exp_adr [$];
	logic [31:0] exp_dat [$];

	cpu_top #(
		.PC_INIT (PC_INIT)
	) i_dut (
		.CLK      (CLK),
		.nRST     (nRST),
		.halt     (halt),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	initial CLK = 1'b0;
	always #4 CLK = ~CLK;

	function automatic logic [31:0] pick(input logic [31:0] n);
		logic [31:0] r;
		r = $random(seed);
		return r % n;
	endfunction

	function automatic logic [31:0] encode_r(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		instr_t w;
		w = '0;
		w.r.opcode = OP_RTYPE;
		w.r.rs     = rs;
		w.r.rt     = rt;
		w.r.rd     = rd;
		w.r.funct  = fn;
		return w;
	endfunction

	function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		instr_t w;
		w.i.opcode = op;
		w.i.rs     = rs;
		w.i.rt     = rt;
		w.i.imm    = imm;
		return w;
	endfunction

	function automatic logic [31:0] encode_j(input logic [5:0] op, input logic [25:0] target);
		instr_t w;
		w.j.opcode = op;
		w.j.target = target;
		return w;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic build_program;
		logic [31:0] kind, off;
		logic [4:0]  rs, rt, rd;
		logic [15:0] imm;
		// fill pattern covers every word, program goes on top
		for (int k = 0; k < MEM_WORDS; k++) begin
			mem[k] = (32'(k) * 32'h9e3779b9) ^ 32'h0000a5c3;
		end
		for (int i = 0; i < RAND_INSTR; i++) begin
			kind = pick(13);
			rs   = 5'(pick(32));
			rt   = 5'(pick(32));
			rd   = 5'(pick(32));
			imm  = 16'(pick(32'h10000));
			// forward targets only, at most into the dump code
			off  = pick(4);
			if (i + 1 + off > RAND_INSTR)
				off = RAND_INSTR - i - 1;
			if (kind >= 10 && pick(2) == 0)
				rt = rs;
			case (kind)
				0:  mem[i] = encode_r(FN_ADDU, rs, rt, rd);
				1:  mem[i] = encode_r(FN_SUBU, rs, rt, rd);
				2:  mem[i] = encode_r(FN_AND, rs, rt, rd);
				3:  mem[i] = encode_r(FN_OR, rs, rt, rd);
				4:  mem[i] = encode_r(FN_SLT, rs, rt, rd);
				5:  mem[i] = encode_i(OP_ADDIU, rs, rt, imm);
				6:  mem[i] = encode_i(OP_ORI, rs, rt, imm);
				7:  mem[i] = encode_i(OP_LUI, 5'd0, rt, imm);
				8:  mem[i] = encode_i(OP_LW, 5'd0, rt, 16'(DATA_BASE + 4 * pick(128)));
				9:  mem[i] = encode_i(OP_SW, 5'd0, rt, 16'(DATA_BASE + 4 * pick(128)));
				10: mem[i] = encode_i(OP_BEQ, rs, rt, 16'(off));
				11: mem[i] = encode_i(OP_BNE, rs, rt, 16'(off));
				default: mem[i] = encode_j(OP_J, 26'(i + 1 + off));
			endcase
		end
		for (int r = 1; r < 32; r++) begin
			mem[RAND_INSTR + r - 1] = encode_i(OP_SW, 5'd0, 5'(r), 16'(DUMP_BASE + 4 * r));
		end
		mem[RAND_INSTR + 31] = encode_j(OP_HALT, 26'd0);
	endtask

	task automatic expect_cycle(input logic we, input logic [31:0] adr, input logic [31:0] dat);
		exp_we.push_back(we);
		exp_adr.push_back(adr);
		exp_dat.push_back(dat);
	endtask

	// instruction-set model, records the bus trace and the final state
	task automatic run_reference;
		logic [31:0] pc, nxt, a, b, sext, addr, val;
		logic [4:0]  dst;
		logic        wr, done;
		instr_t      w;
		int          steps;
		for (int r = 0; r < 32; r++)
			ref_regs[r] = '0;
		for (int k = 0; k < MEM_WORDS; k++)
			ref_mem[k] = mem[k];
		pc    = PC_INIT;
		done  = 1'b0;
		steps = 0;
		while (!done && steps < 1000) begin
			w = ref_mem[pc[11:2]];
			expect_cycle(1'b0, pc, 32'd0);
			a    = ref_regs[w.i.rs];
			b    = ref_regs[w.i.rt];
			sext = {{16{w.i.imm[15]}}, w.i.imm};
			addr = a + sext;
			nxt  = pc + 32'd4;
			dst  = w.i.rt;
			wr   = 1'b1;
			val  = '0;
			case (w.r.opcode)
				OP_RTYPE: begin
					dst = w.r.rd;
					case (w.r.funct)
						FN_ADDU: val = a + b;
						FN_SUBU: val = a - b;
						FN_AND:  val = a & b;
						FN_OR:   val = a | b;
						default: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					endcase
				end
				OP_ADDIU: val = a + sext;
				OP_ORI:   val = a | {16'd0, w.i.imm};
				OP_LUI:   val = {w.i.imm, 16'd0};
				OP_LW: begin
					expect_cycle(1'b0, addr, 32'd0);
					val = ref_mem[addr[11:2]];
				end
				OP_SW: begin
					expect_cycle(1'b1, addr, b);
					ref_mem[addr[11:2]] = b;
					wr = 1'b0;
				end
				OP_BEQ, OP_BNE: begin
					wr = 1'b0;
					if ((a == b) == (w.r.opcode == OP_BEQ))
						nxt = nxt + (sext << 2);
				end
				OP_J: begin
					wr  = 1'b0;
					nxt = {nxt[31:28], w.j.target, 2'b00};
				end
				default: begin
					wr   = 1'b0;
					done = 1'b1;
				end
			endcase
			if (wr && dst != 5'd0)
				ref_regs[dst] = val;
			pc = nxt;
			steps++;
		end
		if (!done) begin
			errors++;
			$display("reference model did not reach HALT");
		end
	endtask

	task automatic serve_cycle;
		logic        e_we;
		logic [31:0] e_adr, e_dat;
		if (wb_adr >= 32'(MEM_WORDS * WORD_BYTES)) begin
			errors++;
			$display("bus address %h is outside the memory model", wb_adr);
		end else if (wb_we) begin
			mem[wb_adr[11:2]] = wb_dat_w;
		end else begin
			wb_dat_r = mem[wb_adr[11:2]];
		end
		if (exp_adr.size() == 0) begin
			errors++;
			$display("bus cycle at %h is not in the reference trace", wb_adr);
		end else begin
			e_we  = exp_we.pop_front();
			e_adr = exp_adr.pop_front();
			e_dat = exp_dat.pop_front();
			check_value("bus cycle write enable", {31'd0, e_we}, {31'd0, wb_we});
			check_value("bus cycle address", e_adr, wb_adr);
			if (e_we)
				check_value("bus store data", e_dat, wb_dat_w);
		end
		check_value("halt during bus cycle", 32'd0, {31'd0, halt});
	endtask

	// wishbone slave, ack after 0 to 3 wait cycles
	always @(negedge CLK) begin
		if (wb_ack) begin
			wb_ack = 1'b0;
		end else if (nRST && wb_stb) begin
			if (!in_cycle) begin
				in_cycle  = 1'b1;
				ack_delay = pick(4);
			end
			if (ack_delay == 0) begin
				serve_cycle();
				in_cycle = 1'b0;
				wb_ack   = 1'b1;
			end else begin
				ack_delay = ack_delay - 1;
			end
		end
	end

	initial begin
		int cycles;
		seed      = 32'h7a163240;
		errors    = 0;
		nRST      = 1'b0;
		wb_ack    = 1'b0;
		wb_dat_r  = '0;
		in_cycle  = 1'b0;
		ack_delay = '0;
		build_program();
		run_reference();

		repeat (10) @(negedge CLK);
		check_value("halt in reset", 32'd0, {31'd0, halt});
		check_value("cyc in reset", 32'd0, {31'd0, wb_cyc});
		check_value("stb in reset", 32'd0, {31'd0, wb_stb});
		nRST = 1'b1;

		cycles = 0;
		while (!wb_stb && cycles < 20) begin
			@(negedge CLK);
			cycles++;
		end
		if (!wb_stb) begin
			errors++;
			$display("timeout waiting for the first bus cycle");
		end else begin
			check_value("first fetch address", PC_INIT, wb_adr);
			check_value("first fetch is a read", 32'd0, {31'd0, wb_we});
		end

		cycles = 0;
		while (!halt && cycles < TIMEOUT) begin
			@(negedge CLK);
			cycles++;
		end
		if (!halt) begin
			errors++;
			$display("timeout waiting for halt");
		end
		check_value("trace entries left", 32'd0, 32'(exp_adr.size()));

		// the bus stays quiet once halted
		for (int c = 0; c < 50; c++) begin
			@(negedge CLK);
			if (wb_cyc || wb_stb) begin
				errors++;
				$display("bus cycle started after halt");
			end
			check_value("halt held", 32'd1, {31'd0, halt});
		end

		for (int r = 1; r < 32; r++)
			check_value($sformatf("register r%0d", r), ref_regs[r], mem[DUMP_BASE / 4 + r]);
		for (int k = 0; k < MEM_WORDS; k++)
			check_value($sformatf("memory word %0d", k), ref_mem[k], mem[k]);

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule
